// File: build.f
+incdir+rtl
rtl/ulpb_pkg.sv
rtl/ulpb_line_sampler.sv
rtl/ulpb_sequencer.sv
rtl/ulpb_line_driver.sv
rtl/ulpb_ctrl.sv
tb/ulpb_ctrl_assert.sv
tb/ulpb_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the ulpb_ctrl testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module ulpb_ctrl_tb -o ulpb_sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/ulpb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

// File: tb/ulpb_ctrl_tb.sv
`timescale 1ns/1ps

`include "ulpb_macros.svh"

module ulpb_ctrl_tb
	import ulpb_pkg::*;
;

	logic CLK_EXT;
	logic RESETn;
	logic CLKIN;
	logic DIN;
	logic CLKOUT;
	logic DOUT;

	logic [15:0] lfsr_state;

	bus_state_t m_state;
	bus_state_t m_state_neg;
	logic       m_clk_en;
	logic       m_clkin_low;
	logic [2:0] m_neg;
	logic [2:0] m_pos;
	int         m_cyc;
	logic       saw_wait;

	ulpb_ctrl UUT
	(
		.CLK_EXT (CLK_EXT),
		.RESETn  (RESETn),
		.CLKIN   (CLKIN),
		.DIN     (DIN),
		.CLKOUT  (CLKOUT),
		.DOUT    (DOUT)
	);

	bind ulpb_ctrl ulpb_ctrl_assert u_assert
	(
		.CLK_EXT   (CLK_EXT),
		.RESETn    (RESETn),
		.CLKOUT    (CLKOUT),
		.bus_state (bus_state)
	);

	initial
	begin
		CLK_EXT = 1'b0;
		forever #10 CLK_EXT = ~CLK_EXT;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);  // one step for each bit taken.
		end
	endtask

	// Next bus state and clock enable, from the timing rules of the bus.
	function automatic void next_bus(input bus_state_t s, input int cyc, input logic din,
		input logic clkin_low, input logic sw, input logic clk_en,
		output bus_state_t ns, output logic nclk);
		ns   = s;
		nclk = clk_en;
		case (s)
			BUS_IDLE:            if (!din) ns = BUS_WAIT_START;
			BUS_WAIT_START:
			begin
				if (cyc >= `ULPB_START_CYCLES - 1)
				begin
					ns   = BUS_ARBITRATE;
					nclk = 1'b1;
				end
			end
			BUS_IDLE_ARBI:       ns = BUS_ARBITRATE;
			BUS_ARBITRATE:       ns = BUS_PRIO;
			BUS_PRIO:            ns = BUS_ACTIVE;
			BUS_ACTIVE:
			begin
				if (clkin_low)
				begin
					ns   = BUS_INTERRUPT;
					nclk = 1'b0;
				end
			end
			BUS_INTERRUPT:
			begin
				if (cyc >= `ULPB_INTERRUPT_CYCLES - 1 && sw)
				begin
					ns   = BUS_SWITCH_ROLE;
					nclk = 1'b1;
				end
			end
			BUS_SWITCH_ROLE:     ns = BUS_LEAVE_INTERRUPT;
			BUS_LEAVE_INTERRUPT: ns = BUS_CONTROL0;
			BUS_CONTROL0:        ns = BUS_CONTROL1;
			BUS_CONTROL1:        ns = BUS_BACK_TO_IDLE;
			BUS_BACK_TO_IDLE:
			begin
				ns   = din ? BUS_IDLE : BUS_IDLE_ARBI;
				nclk = din ? 1'b0 : clk_en;
			end
			default:
			begin
				ns   = BUS_IDLE;
				nclk = 1'b0;
			end
		endcase
	endfunction

	function automatic logic expected_dout(input bus_state_t s, input logic din,
		input logic clk);
		if (s inside {BUS_IDLE, BUS_WAIT_START, BUS_IDLE_ARBI, BUS_ARBITRATE,
			BUS_BACK_TO_IDLE})
			expected_dout = 1'b1;
		else if (s == BUS_INTERRUPT)
			expected_dout = clk;
		else
			expected_dout = din;
	endfunction

	always @(posedge CLK_EXT or negedge RESETn)
	begin
		bus_state_t ns;
		logic       nclk;
		logic       sw;
		if (!RESETn)
		begin
			m_state  = BUS_IDLE;
			m_clk_en = 1'b0;
			m_pos    = 3'b000;
			m_cyc    = 0;
		end
		else
		begin
			sw = (m_neg == 3'b111) && (m_pos == 3'b000);
			next_bus(m_state, m_cyc, DIN, m_clkin_low, sw, m_clk_en, ns, nclk);
			if (m_state == BUS_INTERRUPT)
				m_pos = {m_pos[1:0], DIN};
			m_cyc    = (ns == m_state) ? m_cyc + 1 : 0;
			m_state  = ns;
			m_clk_en = nclk;
		end
	end

	always @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			m_state_neg = BUS_IDLE;
			m_clkin_low = 1'b0;
			m_neg       = 3'b000;
		end
		else
		begin
			if (m_state == BUS_INTERRUPT)
				m_neg = {m_neg[1:0], DIN};
			m_clkin_low = ~CLKIN;
			m_state_neg = m_state;
		end
	end

	// outputs are settled a quarter period after each clock edge.
	initial
	begin
		logic exp_clk;
		logic exp_dout;
		forever
		begin
			@(CLK_EXT);
			#5;
			if (RESETn === 1'b1)
			begin
				exp_clk  = m_clk_en ? CLK_EXT : 1'b1;
				exp_dout = expected_dout(m_state_neg, DIN, CLK_EXT);
				assert (UUT.bus_state === m_state)
				else abort_run($sformatf("Fail at %0t: bus state %0d, expected %0d",
					$time, UUT.bus_state, m_state));
				assert (CLKOUT === exp_clk)
				else abort_run($sformatf("Fail at %0t: CLKOUT is %b, expected %b",
					$time, CLKOUT, exp_clk));
				assert (DOUT === exp_dout)
				else abort_run($sformatf("Fail at %0t: DOUT is %b, expected %b",
					$time, DOUT, exp_dout));
				if (UUT.bus_state == BUS_WAIT_START)
					saw_wait = 1'b1;
			end
		end
	end

	task automatic wait_state(input bus_state_t target, input int limit);
		int n;
		n = 0;
		while (m_state != target)
		begin
			if (n >= limit)
				abort_run($sformatf("timed out waiting for bus state %0d", target));
			else
			begin
				@(negedge CLK_EXT);
				n++;
			end
		end
	endtask

	task automatic idle_gap();
		int n;
		random_bits(4, n);
		repeat (n + 2) @(negedge CLK_EXT);
	endtask

	task automatic active_traffic();
		int n;
		int b;
		random_bits(3, n);
		repeat (n + 2)
		begin
			random_bits(1, b);
			DIN <= b[0];  // forwarded to DOUT while active.
			@(negedge CLK_EXT);
		end
	endtask

	task automatic interrupt_and_switch(input logic din_after);
		int n;
		CLKIN <= 1'b0;
		@(negedge CLK_EXT);
		CLKIN <= 1'b1;
		wait_state(BUS_INTERRUPT, 4);
		DIN <= 1'b1;  // not the role switch pattern.
		repeat (`ULPB_INTERRUPT_CYCLES + 4) @(negedge CLK_EXT);
		assert (UUT.bus_state == BUS_INTERRUPT)
		else abort_run("bus left interrupt without the role switch pattern");
		n = 0;
		while (m_state == BUS_INTERRUPT)
		begin
			if (n >= `ULPB_INTERRUPT_CYCLES + 10)
				abort_run("timed out waiting for the bus to leave interrupt");
			else
			begin
				DIN <= 1'b0;
				@(posedge CLK_EXT);
				DIN <= 1'b1;  // the pattern toggles DIN every half cycle.
				@(negedge CLK_EXT);
				n++;
			end
		end
		DIN <= din_after;
	endtask

	initial
	begin
		lfsr_state = 16'd15;
		saw_wait   = 1'b0;
		RESETn     = 1'b0;
		CLKIN      = 1'b1;
		DIN        = 1'b1;
		repeat (3) @(negedge CLK_EXT);
		RESETn <= 1'b1;

		idle_gap();
		DIN <= 1'b0;
		wait_state(BUS_ACTIVE, `ULPB_START_CYCLES + 10);
		active_traffic();
		interrupt_and_switch(1'b0);

		saw_wait = 1'b0;
		wait_state(BUS_IDLE_ARBI, 10);
		wait_state(BUS_ACTIVE, 5);
		assert (!saw_wait)
		else abort_run("re-arbitration went through the start wait");
		active_traffic();
		interrupt_and_switch(1'b1);
		wait_state(BUS_IDLE, 10);
		idle_gap();

		$display("test passed");
		$finish;
	end

endmodule

// File: tb/ulpb_ctrl_assert.sv
`timescale 1ns/1ps

`include "ulpb_macros.svh"

module ulpb_ctrl_assert
	import ulpb_pkg::*;
(
	input logic       CLK_EXT,
	input logic       RESETn,
	input logic       CLKOUT,
	input bus_state_t bus_state
);

	int   wait_len;
	logic prev_wait;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			wait_len  <= 0;
			prev_wait <= 1'b0;
		end
		else
		begin
			wait_len  <= (bus_state == BUS_WAIT_START) ? wait_len + 1 : 0;
			prev_wait <= (bus_state == BUS_WAIT_START);
		end
	end

	idle_clock_high: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		(bus_state == BUS_IDLE) |-> CLKOUT)
		else $error("CLKOUT low while the bus is idle");

	// checked on the first edge after the start wait has ended.
	start_wait_length: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		(prev_wait && bus_state != BUS_WAIT_START) |-> (wait_len == `ULPB_START_CYCLES))
		else $error("start wait lasted %0d cycles", wait_len);

	state_defined: assert property (@(posedge CLK_EXT) disable iff (!RESETn)
		!$isunknown(bus_state) && (bus_state inside {BUS_IDLE, BUS_WAIT_START,
		BUS_IDLE_ARBI, BUS_ARBITRATE, BUS_PRIO, BUS_ACTIVE, BUS_INTERRUPT,
		BUS_SWITCH_ROLE, BUS_LEAVE_INTERRUPT, BUS_CONTROL0, BUS_CONTROL1,
		BUS_BACK_TO_IDLE}))
		else $error("bus state holds an undefined encoding");

endmodule

// File: rtl/ulpb_ctrl.sv
`timescale 1ns/1ps

module ulpb_ctrl
	import ulpb_pkg::*;
(
	input  logic CLK_EXT,
	input  logic RESETn,
	input  logic CLKIN,
	input  logic DIN,
	output logic CLKOUT,
	output logic DOUT
);

	bus_state_t bus_state;
	logic       clk_en;
	logic       clkin_low;
	logic       switch_pattern;

	ulpb_line_sampler u_sampler
	(
		.CLK_EXT        (CLK_EXT),
		.RESETn         (RESETn),
		.CLKIN          (CLKIN),
		.DIN            (DIN),
		.bus_state      (bus_state),
		.clkin_low      (clkin_low),
		.switch_pattern (switch_pattern)
	);

	ulpb_sequencer u_sequencer
	(
		.CLK_EXT        (CLK_EXT),
		.RESETn         (RESETn),
		.DIN            (DIN),
		.clkin_low      (clkin_low),
		.switch_pattern (switch_pattern),
		.bus_state      (bus_state),
		.clk_en         (clk_en)
	);

	ulpb_line_driver u_driver
	(
		.CLK_EXT   (CLK_EXT),
		.RESETn    (RESETn),
		.DIN       (DIN),
		.bus_state (bus_state),
		.clk_en    (clk_en),
		.CLKOUT    (CLKOUT),
		.DOUT      (DOUT)
	);

endmodule

// File: rtl/ulpb_line_driver.sv
`timescale 1ns/1ps

module ulpb_line_driver
	import ulpb_pkg::*;
(
	input  logic       CLK_EXT,
	input  logic       RESETn,
	input  logic       DIN,
	input  bus_state_t bus_state,
	input  logic       clk_en,
	output logic       CLKOUT,
	output logic       DOUT
);

	bus_state_t state_neg;

	// DOUT moves half a cycle after the state, on the falling edge.
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			state_neg <= BUS_IDLE;
		end
		else
		begin
			state_neg <= bus_state;
		end
	end

	assign CLKOUT = clk_en ? CLK_EXT : 1'b1;  // the ring idles high.

	always_comb
	begin
		case (state_neg)
			BUS_IDLE,
			BUS_WAIT_START,
			BUS_IDLE_ARBI,
			BUS_ARBITRATE,
			BUS_BACK_TO_IDLE:
			begin
				DOUT = 1'b1;
			end

			BUS_INTERRUPT:
			begin
				DOUT = CLK_EXT;  // signature that tells the nodes of the interrupt.
			end

			default:
			begin
				DOUT = DIN;
			end
		endcase
	end

endmodule

// File: rtl/ulpb_sequencer.sv
`timescale 1ns/1ps

`include "ulpb_macros.svh"

module ulpb_sequencer
	import ulpb_pkg::*;
(
	input  logic       CLK_EXT,
	input  logic       RESETn,
	input  logic       DIN,
	input  logic       clkin_low,
	input  logic       switch_pattern,
	output bus_state_t bus_state,
	output logic       clk_en
);

	localparam logic [`ULPB_COUNT_W-1:0] START_LOAD =
		`ULPB_COUNT_W'(`ULPB_START_CYCLES - 1);
	localparam logic [`ULPB_COUNT_W-1:0] INTERRUPT_LOAD =
		`ULPB_COUNT_W'(`ULPB_INTERRUPT_CYCLES - 1);

	bus_state_t              next_state;
	logic                    next_clk_en;
	logic [`ULPB_COUNT_W-1:0] start_cnt;
	logic [`ULPB_COUNT_W-1:0] next_start_cnt;
	logic [`ULPB_COUNT_W-1:0] int_cnt;
	logic [`ULPB_COUNT_W-1:0] next_int_cnt;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			bus_state <= BUS_IDLE;
		end
		else
		begin
			bus_state <= next_state;
		end
	end

	// Changes only on a rising edge, while CLK_EXT is high,
	// so the gated clock never sees a short pulse.
	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clk_en <= 1'b0;
		end
		else
		begin
			clk_en <= next_clk_en;
		end
	end

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			start_cnt <= START_LOAD;
		end
		else
		begin
			start_cnt <= next_start_cnt;
		end
	end

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			int_cnt <= INTERRUPT_LOAD;
		end
		else
		begin
			int_cnt <= next_int_cnt;
		end
	end

	always_comb
	begin
		next_state     = bus_state;
		next_clk_en    = clk_en;
		next_start_cnt = start_cnt;
		next_int_cnt   = int_cnt;

		case (bus_state)
			BUS_IDLE:
			begin
				next_start_cnt = START_LOAD;  // armed for the next request.
				if (!DIN)
				begin
					next_state = BUS_WAIT_START;
				end
			end

			BUS_WAIT_START:
			begin
				if (start_cnt != '0)
				begin
					next_start_cnt = start_cnt - 1'b1;
				end
				else
				begin
					next_clk_en = 1'b1;
					next_state  = BUS_ARBITRATE;
				end
			end

			BUS_IDLE_ARBI:
			begin
				next_state = BUS_ARBITRATE;  // clock is still running here.
			end

			BUS_ARBITRATE:
			begin
				next_state = BUS_PRIO;
			end

			BUS_PRIO:
			begin
				next_state = BUS_ACTIVE;
			end

			BUS_ACTIVE:
			begin
				next_int_cnt = INTERRUPT_LOAD;
				if (clkin_low)
				begin
					next_clk_en = 1'b0;
					next_state  = BUS_INTERRUPT;
				end
			end

			BUS_INTERRUPT:
			begin
				if (int_cnt != '0)
				begin
					next_int_cnt = int_cnt - 1'b1;
				end
				else if (switch_pattern)
				begin
					next_clk_en = 1'b1;
					next_state  = BUS_SWITCH_ROLE;
				end
			end

			BUS_SWITCH_ROLE:
			begin
				next_state = BUS_LEAVE_INTERRUPT;
			end

			BUS_LEAVE_INTERRUPT:
			begin
				next_state = BUS_CONTROL0;
			end

			BUS_CONTROL0:
			begin
				next_state = BUS_CONTROL1;
			end

			BUS_CONTROL1:
			begin
				next_state = BUS_BACK_TO_IDLE;
			end

			BUS_BACK_TO_IDLE:
			begin
				// A node already holding DIN low skips the start wait.
				if (!DIN)
				begin
					next_state = BUS_IDLE_ARBI;
				end
				else
				begin
					next_clk_en = 1'b0;
					next_state  = BUS_IDLE;
				end
			end

			default:
			begin
				next_clk_en = 1'b0;
				next_state  = BUS_IDLE;
			end
		endcase
	end

endmodule

// File: rtl/ulpb_line_sampler.sv
`timescale 1ns/1ps

module ulpb_line_sampler
	import ulpb_pkg::*;
(
	input  logic       CLK_EXT,
	input  logic       RESETn,
	input  logic       CLKIN,
	input  logic       DIN,
	input  bus_state_t bus_state,
	output logic       clkin_low,
	output logic       switch_pattern
);

	logic       in_interrupt;
	logic [2:0] din_neg;
	logic [2:0] din_pos;

	assign in_interrupt = (bus_state == BUS_INTERRUPT);

	// An interrupting node pulls CLKIN low while the clock is high.
	// The sample is taken on the falling edge so that the sequencer
	// sees a settled level on the next rising edge.
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clkin_low <= 1'b0;
		end
		else
		begin
			clkin_low <= ~CLKIN;
		end
	end

	// the high half of each clock cycle.
	always_ff @(negedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			din_neg <= 3'b000;
		end
		else if (in_interrupt)
		begin
			din_neg <= {din_neg[1:0], DIN};
		end
	end

	// the low half of each clock cycle.
	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			din_pos <= 3'b000;
		end
		else if (in_interrupt)
		begin
			din_pos <= {din_pos[1:0], DIN};
		end
	end

	// The role switch shows DIN toggling in step with CLK_EXT for three cycles.
	assign switch_pattern = (din_neg == 3'b111) && (din_pos == 3'b000);

endmodule

// File: rtl/ulpb_pkg.sv
`include "ulpb_macros.svh"

package ulpb_pkg;

	// Bus states of the controller.
	// The encoding is kept sparse, so codes 10, 13, 14 and 15 are unused.
	typedef enum logic [`ULPB_STATE_W-1:0]
	{
		BUS_IDLE            = 4'd0,
		BUS_WAIT_START      = 4'd1,
		BUS_ARBITRATE       = 4'd2,
		BUS_PRIO            = 4'd3,
		BUS_ACTIVE          = 4'd4,
		BUS_INTERRUPT       = 4'd5,
		BUS_SWITCH_ROLE     = 4'd6,
		BUS_LEAVE_INTERRUPT = 4'd7,
		BUS_CONTROL0        = 4'd8,
		BUS_CONTROL1        = 4'd9,
		BUS_BACK_TO_IDLE    = 4'd11,
		BUS_IDLE_ARBI       = 4'd12
	} bus_state_t;

endpackage

// File: rtl/ulpb_macros.svh
`ifndef ULPB_MACROS_SVH
`define ULPB_MACROS_SVH

// Bus timing in cycles of CLK_EXT.

// cycles between a bus request and the first gated clock.
`define ULPB_START_CYCLES 10

// cycles spent in interrupt before the role-switch pattern is honoured.
`define ULPB_INTERRUPT_CYCLES 6

// Register widths.

// width of the bus state encoding.
`define ULPB_STATE_W 4

// width of both countdown counters.
`define ULPB_COUNT_W 4

`endif
